// ==== eeprom_pkg.sv ====
package eeprom_pkg;

    // host side widths
    localparam int ADDR_W = 11;
    localparam int DATA_W = 8;

    // opcode in the top bit, then address, then data
    localparam int CMD_W = 1 + ADDR_W + DATA_W;

    // address byte on the wire, the rest rides in the control byte
    localparam int ADDR_LO_W = 8;
    localparam int ADDR_HI_W = ADDR_W - ADDR_LO_W;

    localparam logic [3:0] DEV_CODE = 4'b1010;

    typedef enum logic {
        op_write = 1'b0,
        op_read  = 1'b1
    } eeprom_op_t;

    typedef enum logic [3:0] {
        st_idle,
        st_start,
        st_ctrl_wr,
        st_addr,
        st_data_wr,
        st_restart,
        st_ctrl_rd,
        st_data_rd,
        st_stop,
        st_ack
    } ctrl_state_t;

    // 1010, block address, r/w bit
    function automatic logic [DATA_W-1:0] ctrl_byte(
        input logic [ADDR_HI_W-1:0] addr_hi,
        input eeprom_op_t op
    );
        return {DEV_CODE, addr_hi, op == op_read};
    endfunction

endpackage

// ==== eeprom_cmd_capture.sv ====
`timescale 1ns/1ps

module eeprom_cmd_capture (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          wr,
    input  logic                          rd,
    input  logic [eeprom_pkg::ADDR_W-1:0] addr,
    input  logic [eeprom_pkg::DATA_W-1:0] wr_data,
    input  logic                          full,
    output logic                          push,
    output logic [eeprom_pkg::CMD_W-1:0]  push_cmd,
    output logic                          overflow
);

    eeprom_pkg::eeprom_op_t op;
    logic                   strobe;
    logic                   accept;

    assign strobe = wr | rd;
    assign accept = strobe & ~full;

    // write wins when both strobes arrive together
    always_comb
    begin
        if (wr)
            op = eeprom_pkg::op_write;
        else
            op = eeprom_pkg::op_read;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            push     <= 1'b0;
            overflow <= 1'b0;
        end
        else
        begin
            push <= accept;
            if (strobe && full)
                overflow <= 1'b1; // sticky until reset
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
            push_cmd <= {op, addr, wr_data};
    end

endmodule

// ==== eeprom_cmd_fifo.sv ====
`timescale 1ns/1ps

module eeprom_cmd_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                         CLK,
    input  logic                         RESET,
    input  logic                         push,
    input  logic [eeprom_pkg::CMD_W-1:0] push_cmd,
    input  logic                         pop,
    output logic [eeprom_pkg::CMD_W-1:0] head_cmd,
    output logic                         empty,
    output logic                         full
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    logic [eeprom_pkg::CMD_W-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]             wr_ptr;
    logic [PTR_W-1:0]             rd_ptr;
    logic [PTR_W:0]               count;
    logic [PTR_W:0]               count_next;

    assign count_next = count + {{PTR_W{1'b0}}, push} - {{PTR_W{1'b0}}, pop};

    // looks one push ahead since the capture stage has a register in front
    assign full     = (count_next == (PTR_W + 1)'(FIFO_DEPTH));
    assign empty    = (count == '0);
    assign head_cmd = mem[rd_ptr];

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1; // wraps, depth is a power of two
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count_next;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (push)
            mem[wr_ptr] <= push_cmd;
    end

endmodule

// ==== eeprom_serial_ctrl.sv ====
`timescale 1ns/1ps

module eeprom_serial_ctrl (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          empty,
    input  logic [eeprom_pkg::CMD_W-1:0]  head_cmd,
    output logic                          pop,
    output logic                          scl,
    output logic                          sda_out,
    output logic                          sda_oe,
    input  logic                          sda_in,
    output logic                          ack,
    output logic [eeprom_pkg::DATA_W-1:0] rd_data,
    output logic                          rd_valid
);

    localparam int CNT_W  = $clog2(eeprom_pkg::DATA_W);
    localparam int DATA_W = eeprom_pkg::DATA_W;
    localparam int ADDR_W = eeprom_pkg::ADDR_W;

    eeprom_pkg::ctrl_state_t state;
    eeprom_pkg::eeprom_op_t  cmd_op;
    logic [ADDR_W-1:0]       cmd_addr;
    logic [DATA_W-1:0]       cmd_data;
    logic [DATA_W-1:0]       shift_reg;
    logic [CNT_W-1:0]        bit_cnt;
    logic                    last_bit;

    assign pop      = (state == eeprom_pkg::st_idle) && !empty;
    assign last_bit = (bit_cnt == CNT_W'(DATA_W - 1));

    // latch the head entry as it leaves the fifo
    always_ff @(posedge CLK)
    begin
        if (pop)
        begin
            cmd_op   <= eeprom_pkg::eeprom_op_t'(head_cmd[eeprom_pkg::CMD_W-1]);
            cmd_addr <= head_cmd[eeprom_pkg::CMD_W-2 -: ADDR_W];
            cmd_data <= head_cmd[DATA_W-1:0];
        end
    end

    // every bit is a falling edge with new sda, then a rising edge
    // start, restart and stop hold scl high while sda moves
    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= eeprom_pkg::st_idle;
            scl       <= 1'b0;
            sda_out   <= 1'b1;
            sda_oe    <= 1'b1;
            ack       <= 1'b0;
            rd_valid  <= 1'b0;
            rd_data   <= '0;
            shift_reg <= '0;
            bit_cnt   <= '0;
        end
        else
        begin
            case (state)
                eeprom_pkg::st_idle:
                begin
                    scl     <= 1'b0;
                    sda_out <= 1'b1; // bus idle
                    sda_oe  <= 1'b1;
                    bit_cnt <= '0;
                    if (!empty)
                        state <= eeprom_pkg::st_start;
                end
                eeprom_pkg::st_start:
                begin
                    if (bit_cnt == '0)
                    begin
                        scl     <= 1'b1;
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                    else
                    begin
                        sda_out   <= 1'b0; // falls under high scl
                        shift_reg <= eeprom_pkg::ctrl_byte(
                            cmd_addr[ADDR_W-1 -: eeprom_pkg::ADDR_HI_W], eeprom_pkg::op_write);
                        bit_cnt   <= '0;
                        state     <= eeprom_pkg::st_ctrl_wr;
                    end
                end
                eeprom_pkg::st_ctrl_wr,
                eeprom_pkg::st_addr,
                eeprom_pkg::st_data_wr,
                eeprom_pkg::st_ctrl_rd:
                begin
                    if (scl)
                    begin
                        scl       <= 1'b0;
                        sda_out   <= shift_reg[DATA_W-1]; // msb first
                        shift_reg <= {shift_reg[DATA_W-2:0], 1'b0};
                    end
                    else
                    begin
                        scl     <= 1'b1;
                        bit_cnt <= bit_cnt + 1'b1; // wraps to zero after the last bit
                        if (last_bit)
                        begin
                            case (state)
                                eeprom_pkg::st_ctrl_wr:
                                begin
                                    shift_reg <= cmd_addr[eeprom_pkg::ADDR_LO_W-1:0];
                                    state     <= eeprom_pkg::st_addr;
                                end
                                eeprom_pkg::st_addr:
                                begin
                                    if (cmd_op == eeprom_pkg::op_read)
                                        state <= eeprom_pkg::st_restart;
                                    else
                                    begin
                                        shift_reg <= cmd_data;
                                        state     <= eeprom_pkg::st_data_wr;
                                    end
                                end
                                eeprom_pkg::st_data_wr:
                                    state <= eeprom_pkg::st_stop;
                                default:
                                    state <= eeprom_pkg::st_data_rd;
                            endcase
                        end
                    end
                end
                eeprom_pkg::st_restart:
                begin
                    case (bit_cnt)
                        CNT_W'(0):
                        begin
                            scl     <= 1'b0;
                            sda_out <= 1'b1;
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                        CNT_W'(1):
                        begin
                            scl     <= 1'b1;
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                        default:
                        begin
                            sda_out   <= 1'b0; // repeated start
                            shift_reg <= eeprom_pkg::ctrl_byte(
                                cmd_addr[ADDR_W-1 -: eeprom_pkg::ADDR_HI_W], eeprom_pkg::op_read);
                            bit_cnt   <= '0;
                            state     <= eeprom_pkg::st_ctrl_rd;
                        end
                    endcase
                end
                eeprom_pkg::st_data_rd:
                begin
                    if (scl)
                    begin
                        scl    <= 1'b0;
                        sda_oe <= 1'b0; // device drives sda
                    end
                    else
                    begin
                        scl       <= 1'b1;
                        shift_reg <= {shift_reg[DATA_W-2:0], sda_in};
                        bit_cnt   <= bit_cnt + 1'b1;
                        if (last_bit)
                            state <= eeprom_pkg::st_stop;
                    end
                end
                eeprom_pkg::st_stop:
                begin
                    case (bit_cnt)
                        CNT_W'(0):
                        begin
                            scl     <= 1'b0;
                            sda_oe  <= 1'b1;
                            sda_out <= 1'b0;
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                        CNT_W'(1):
                        begin
                            scl     <= 1'b1;
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                        default:
                        begin
                            sda_out <= 1'b1; // rises under high scl
                            bit_cnt <= '0;
                            ack     <= 1'b1;
                            if (cmd_op == eeprom_pkg::op_read)
                            begin
                                rd_valid <= 1'b1;
                                rd_data  <= shift_reg;
                            end
                            state <= eeprom_pkg::st_ack;
                        end
                    endcase
                end
                eeprom_pkg::st_ack:
                begin
                    scl      <= 1'b0;
                    ack      <= 1'b0;
                    rd_valid <= 1'b0;
                    state    <= eeprom_pkg::st_idle;
                end
                default:
                    state <= eeprom_pkg::st_idle;
            endcase
        end
    end

endmodule

// ==== eeprom_top.sv ====
`timescale 1ns/1ps

module eeprom_top #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          wr,
    input  logic                          rd,
    input  logic [eeprom_pkg::ADDR_W-1:0] addr,
    input  logic [eeprom_pkg::DATA_W-1:0] wr_data,
    output logic                          full,
    output logic                          overflow,
    output logic                          ack,
    output logic [eeprom_pkg::DATA_W-1:0] rd_data,
    output logic                          rd_valid,
    output logic                          scl,
    output logic                          sda_out,
    output logic                          sda_oe,
    input  logic                          sda_in
);

    logic                         push;
    logic [eeprom_pkg::CMD_W-1:0] push_cmd;
    logic                         pop;
    logic [eeprom_pkg::CMD_W-1:0] head_cmd;
    logic                         empty;

    eeprom_cmd_capture capture_i (
        .CLK      (CLK),
        .RESET    (RESET),
        .wr       (wr),
        .rd       (rd),
        .addr     (addr),
        .wr_data  (wr_data),
        .full     (full),
        .push     (push),
        .push_cmd (push_cmd),
        .overflow (overflow)
    );

    eeprom_cmd_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) fifo_i (
        .CLK      (CLK),
        .RESET    (RESET),
        .push     (push),
        .push_cmd (push_cmd),
        .pop      (pop),
        .head_cmd (head_cmd),
        .empty    (empty),
        .full     (full)
    );

    eeprom_serial_ctrl ctrl_i (
        .CLK      (CLK),
        .RESET    (RESET),
        .empty    (empty),
        .head_cmd (head_cmd),
        .pop      (pop),
        .scl      (scl),
        .sda_out  (sda_out),
        .sda_oe   (sda_oe),
        .sda_in   (sda_in),
        .ack      (ack),
        .rd_data  (rd_data),
        .rd_valid (rd_valid)
    );

endmodule

// ==== eeprom_slave_model.sv ====
`timescale 1ns/1ps

module eeprom_slave_model (
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,
    output logic sda_drive
);

    localparam int ADDR_W   = eeprom_pkg::ADDR_W;
    localparam int DATA_W   = eeprom_pkg::DATA_W;
    localparam int MEM_SIZE = 1 << ADDR_W;

    typedef enum logic [2:0] {
        ph_idle,
        ph_ctrl,
        ph_addr,
        ph_data,
        ph_read,
        ph_done
    } phase_t;

    logic [DATA_W-1:0]                 mem [MEM_SIZE];
    phase_t                            phase;
    logic                              scl_q;
    logic                              sda_q;
    logic [2:0]                        bit_cnt;
    logic [DATA_W-1:0]                 rx_reg;
    logic [DATA_W-1:0]                 rx_byte;
    logic [DATA_W-1:0]                 tx_reg;
    logic [eeprom_pkg::ADDR_HI_W-1:0]  addr_hi;
    logic [eeprom_pkg::ADDR_LO_W-1:0]  addr_lo;
    logic                              start_seen;
    logic                              stop_seen;
    logic                              scl_rise;

    // bus decoded from values sampled on CLK
    assign start_seen = scl_q && scl && sda_q && !sda;
    assign stop_seen  = scl_q && scl && !sda_q && sda;
    assign scl_rise   = !scl_q && scl;
    assign rx_byte    = {rx_reg[DATA_W-2:0], sda};
    assign sda_drive  = tx_reg[DATA_W-1];

    initial
    begin
        for (int i = 0; i < MEM_SIZE; i++)
            mem[i] = 8'hff; // erased device
    end

    always @(posedge CLK)
    begin
        if (RESET)
        begin
            scl_q   <= 1'b0;
            sda_q   <= 1'b1;
            phase   <= ph_idle;
            bit_cnt <= '0;
            rx_reg  <= '0;
            tx_reg  <= '1;
        end
        else
        begin
            scl_q <= scl;
            sda_q <= sda;
            if (start_seen)
            begin
                phase   <= ph_ctrl; // also taken on a repeated start
                bit_cnt <= '0;
            end
            else if (stop_seen)
                phase <= ph_idle;
            else if (scl_rise)
            begin
                bit_cnt <= bit_cnt + 1'b1;
                if (phase == ph_read)
                begin
                    // next bit leaves as the controller drops scl
                    tx_reg <= {tx_reg[DATA_W-2:0], 1'b1};
                    if (bit_cnt == 3'd7)
                        phase <= ph_done;
                end
                else if (phase == ph_ctrl || phase == ph_addr || phase == ph_data)
                begin
                    rx_reg <= rx_byte;
                    if (bit_cnt == 3'd7)
                    begin
                        case (phase)
                            ph_ctrl:
                            begin
                                addr_hi <= rx_byte[3:1];
                                if (rx_byte[7:4] != eeprom_pkg::DEV_CODE)
                                    phase <= ph_done; // not addressed
                                else if (rx_byte[0])
                                begin
                                    tx_reg <= mem[{rx_byte[3:1], addr_lo}];
                                    phase  <= ph_read;
                                end
                                else
                                    phase <= ph_addr;
                            end
                            ph_addr:
                            begin
                                addr_lo <= rx_byte;
                                phase   <= ph_data;
                            end
                            default:
                            begin
                                mem[{addr_hi, addr_lo}] <= rx_byte;
                                phase                   <= ph_done;
                            end
                        endcase
                    end
                end
            end
        end
    end

endmodule

// ==== eeprom_assertions.sv ====
`timescale 1ns/1ps

module eeprom_assertions (
    input logic                    CLK,
    input logic                    RESET,
    input logic                    ack,
    input logic                    rd_valid,
    input logic                    scl,
    input logic                    sda_out,
    input eeprom_pkg::ctrl_state_t state
);

    ack_one_cycle: assert property (@(posedge CLK) disable iff (RESET) ack |=> !ack)
        else $error("ack held longer than one cycle");

    rd_valid_with_ack: assert property (@(posedge CLK) disable iff (RESET) rd_valid |-> ack)
        else $error("rd_valid without ack");

    // only start, restart and stop may move sda under a high scl
    sda_stable_scl_high: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && !$stable(sda_out)) |->
            ($past(state) inside {eeprom_pkg::st_start, eeprom_pkg::st_restart,
                                  eeprom_pkg::st_stop}))
        else $error("sda_out changed while scl was high");

endmodule

bind eeprom_serial_ctrl eeprom_assertions assertions_i (
    .CLK      (CLK),
    .RESET    (RESET),
    .ack      (ack),
    .rd_valid (rd_valid),
    .scl      (scl),
    .sda_out  (sda_out),
    .state    (state)
);

// ==== tb_eeprom_top.sv ====
`timescale 1ns/1ps

module tb_eeprom_top;

    localparam int ADDR_W        = eeprom_pkg::ADDR_W;
    localparam int DATA_W        = eeprom_pkg::DATA_W;
    localparam int CLK_PERIOD    = 20;
    localparam int DRIVE_DELAY   = 1;
    localparam int CMD_CYCLES    = 60;
    localparam int MARGIN_CYCLES = 2000;

    logic              CLK;
    logic              RESET;
    logic              wr;
    logic              rd;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wr_data;
    logic              full;
    logic              overflow;
    logic              ack;
    logic [DATA_W-1:0] rd_data;
    logic              rd_valid;
    logic              scl;
    logic              sda_out;
    logic              sda_oe;
    logic              sda_in;
    logic              sda_model;

    logic [DATA_W-1:0] ref_mem [1 << ADDR_W];
    logic [DATA_W-1:0] exp_q [$];
    logic [DATA_W-1:0] got_q [$];
    int                ack_count = 0;
    int                rdv_count = 0;
    int                exp_acks  = 0;
    int                exp_rdv   = 0;

    assign sda_in = sda_oe ? sda_out : sda_model; // controller wins when enabled

    eeprom_top dut_i (
        .CLK      (CLK),
        .RESET    (RESET),
        .wr       (wr),
        .rd       (rd),
        .addr     (addr),
        .wr_data  (wr_data),
        .full     (full),
        .overflow (overflow),
        .ack      (ack),
        .rd_data  (rd_data),
        .rd_valid (rd_valid),
        .scl      (scl),
        .sda_out  (sda_out),
        .sda_oe   (sda_oe),
        .sda_in   (sda_in)
    );

    eeprom_slave_model model_i (
        .CLK       (CLK),
        .RESET     (RESET),
        .scl       (scl),
        .sda       (sda_in),
        .sda_drive (sda_model)
    );

    initial
    begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    always @(posedge CLK)
    begin
        if (ack)
            ack_count++;
        if (rd_valid)
        begin
            rdv_count++;
            got_q.push_back(rd_data);
        end
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Test failures found");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_data(input string name, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
        if (got !== exp)
            report_failure($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            report_failure($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp)
            report_failure($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
    endtask

    function automatic logic [DATA_W-1:0] rand_byte();
        return DATA_W'($urandom);
    endfunction

    task automatic next_cycle();
        @(posedge CLK);
        #DRIVE_DELAY;
    endtask

    task automatic send_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
        while (full)
            next_cycle();
        wr      = 1'b1;
        addr    = a;
        wr_data = d;
        next_cycle();
        wr          = 1'b0;
        ref_mem[a]  = d;
        exp_acks++;
    endtask

    task automatic send_read(input logic [ADDR_W-1:0] a);
        while (full)
            next_cycle();
        rd   = 1'b1;
        addr = a;
        next_cycle();
        rd = 1'b0;
        exp_q.push_back(ref_mem[a]); // reads complete in fifo order
        exp_acks++;
        exp_rdv++;
    endtask

    task automatic wait_done();
        wait (ack_count >= exp_acks);
        next_cycle();
        check_count("ack count", ack_count, exp_acks);
        check_count("rd_valid count", rdv_count, exp_rdv);
        while (exp_q.size() > 0)
            check_data("rd_data", got_q.pop_front(), exp_q.pop_front());
    endtask

    task automatic test_reset_state();
        check_flag("scl", scl, 1'b0);
        check_flag("sda_oe", sda_oe, 1'b1);
        check_flag("sda_out", sda_out, 1'b1);
        check_flag("ack", ack, 1'b0);
        check_flag("rd_valid", rd_valid, 1'b0);
        check_flag("full", full, 1'b0);
        check_flag("overflow", overflow, 1'b0);
    endtask

    task automatic test_single();
        send_write(11'h05a, rand_byte());
        send_read(11'h05a);
        wait_done();
    endtask

    task automatic test_back_to_back();
        logic [ADDR_W-1:0] addrs [4];
        addrs = '{11'h010, 11'h011, 11'h123, 11'h7fe};
        foreach (addrs[i])
            send_write(addrs[i], rand_byte());
        foreach (addrs[i])
            send_read(addrs[i]);
        send_read(11'h020); // never written
        send_read(11'h3c4);
        wait_done();
    endtask

    task automatic test_high_bits();
        logic [DATA_W-1:0] d;
        d = rand_byte();
        send_write(11'h0a5, d);
        send_write(11'h5a5, ~d); // same low byte, other block
        send_read(11'h0a5);
        send_read(11'h5a5);
        wait_done();
    endtask

    task automatic test_both_strobes();
        logic [DATA_W-1:0] d;
        d = rand_byte();
        while (full)
            next_cycle();
        wr      = 1'b1;
        rd      = 1'b1;
        addr    = 11'h2b7;
        wr_data = d;
        next_cycle();
        wr = 1'b0;
        rd = 1'b0;
        ref_mem[11'h2b7] = d;
        exp_acks++;
        send_read(11'h2b7);
        wait_done();
        check_flag("overflow", overflow, 1'b0);
    endtask

    task automatic test_overflow();
        logic [ADDR_W-1:0] addr_q [$];
        logic [ADDR_W-1:0] a;
        logic [DATA_W-1:0] d;
        int                burst;
        int                room;
        burst = dut_i.FIFO_DEPTH + 3;
        room  = dut_i.FIFO_DEPTH + 1; // queued entries plus the one in service
        for (int i = 0; i < burst; i++)
        begin
            a       = ADDR_W'(1024 + i * 37);
            d       = rand_byte();
            wr      = 1'b1;
            addr    = a;
            wr_data = d;
            if (i < room)
            begin
                check_flag("full", full, 1'b0);
                ref_mem[a] = d;
                exp_acks++;
            end
            else
                check_flag("full", full, 1'b1); // this strobe is dropped
            addr_q.push_back(a);
            next_cycle();
        end
        wr = 1'b0;
        wait_done();
        check_flag("overflow", overflow, 1'b1);
        foreach (addr_q[i])
            send_read(addr_q[i]);
        wait_done();
        check_flag("overflow", overflow, 1'b1); // sticky
    endtask

    initial
    begin
        int cmd_total;
        cmd_total = 18 + 2 * (dut_i.FIFO_DEPTH + 3);
        #(cmd_total * CMD_CYCLES * CLK_PERIOD + MARGIN_CYCLES * CLK_PERIOD);
        report_failure("timeout, the DUT did not complete all commands in time");
    end

    initial
    begin
        RESET   = 1'b1;
        wr      = 1'b0;
        rd      = 1'b0;
        addr    = '0;
        wr_data = '0;
        void'($urandom(32'h388b));
        for (int i = 0; i < (1 << ADDR_W); i++)
            ref_mem[i] = 8'hff;
        repeat (3) @(posedge CLK);
        #DRIVE_DELAY;
        RESET = 1'b0;
        test_reset_state();
        test_single();
        test_back_to_back();
        test_high_bits();
        test_both_strobes();
        test_overflow();
        $display("All tests passed!");
        $finish;
    end

endmodule

// ==== tb.f ====
eeprom_pkg.sv
eeprom_cmd_capture.sv
eeprom_cmd_fifo.sv
eeprom_serial_ctrl.sv
eeprom_top.sv
eeprom_slave_model.sv
eeprom_assertions.sv
tb_eeprom_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_eeprom_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All tests passed!

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
